//--- Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module calc_top \
		logic/calc_pkg.sv logic/keypad_scanner.sv logic/calc_controller.sv \
		logic/calc_arith.sv logic/calc_top.sv

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module calc_tb -o calc_sim
	@out=$$(./obj_dir/calc_sim); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

//--- logic/calc_arith.sv
`timescale 1ns/1ps

module calc_arith #(
    parameter int DATA_WIDTH = 16  // signed operand width
) (
    input  logic signed [DATA_WIDTH-1:0] operand_a,
    input  logic signed [DATA_WIDTH-1:0] operand_b,
    input  calc_pkg::op_code_t           op,
    output logic signed [DATA_WIDTH-1:0] sum_out,   // truncated result
    output logic                         overflow   // true result out of range
);
    import calc_pkg::*;

    localparam int WIDE = 2 * DATA_WIDTH;  // exact for product too

    logic signed [WIDE-1:0]       a_ext;
    logic signed [WIDE-1:0]       b_ext;
    logic signed [WIDE-1:0]       full;       // exact result
    logic signed [DATA_WIDTH-1:0] trunc;
    logic signed [WIDE-1:0]       trunc_ext;  // truncated, widened back

    assign a_ext = operand_a;  // sign extends
    assign b_ext = operand_b;

    always_comb begin
        case (op)
            OP_ADD:  full = a_ext + b_ext;
            OP_SUB:  full = a_ext - b_ext;
            OP_MUL:  full = a_ext * b_ext;
            default: full = b_ext;  // unknown op passes b
        endcase
    end

    assign trunc     = full[DATA_WIDTH-1:0];
    assign trunc_ext = trunc;

    // lost bits show up as a mismatch
    assign overflow = (trunc_ext != full);
    assign sum_out  = trunc;

endmodule

//--- logic/calc_controller.sv
`timescale 1ns/1ps

module calc_controller #(
    parameter int DATA_WIDTH = 16  // signed operand width
) (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic                         read_input,      // token waiting
    input  calc_pkg::key_token_t         token,
    output logic                         key_read,        // one cycle per token
    output logic signed [DATA_WIDTH-1:0] operand_a,
    output logic signed [DATA_WIDTH-1:0] operand_b,
    output calc_pkg::op_code_t           op,
    input  logic signed [DATA_WIDTH-1:0] sum_out,         // from arith unit
    input  logic                         arith_overflow,
    output logic signed [DATA_WIDTH-1:0] display_value,
    output logic                         result_valid,
    output logic                         overflow
);
    import calc_pkg::*;

    localparam int WIDE = DATA_WIDTH + 5;  // room for x10 plus a digit

    logic signed [DATA_WIDTH-1:0] entry;       // number being typed
    logic                         entry_neg;   // digits subtract when set
    logic signed [WIDE-1:0]       entry_wide;
    logic signed [WIDE-1:0]       digit_wide;
    logic signed [WIDE-1:0]       appended;    // entry with next digit
    logic                         digit_fits;

    // next entry value for a digit token
    always_comb begin
        entry_wide = entry;  // sign extends
        digit_wide = WIDE'(token.payload.digit);
        if (entry_neg) begin
            appended = entry_wide * WIDE'(10) - digit_wide;
        end else begin
            appended = entry_wide * WIDE'(10) + digit_wide;
        end
    end

    // upper bits must all match the new sign bit
    assign digit_fits = (appended[WIDE-1:DATA_WIDTH-1] ==
                         {(WIDE - DATA_WIDTH + 1){appended[DATA_WIDTH-1]}});

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_read     <= 1'b0;
            entry        <= '0;
            entry_neg    <= 1'b0;
            operand_a    <= '0;
            op           <= OP_NONE;
            result_valid <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            key_read     <= read_input && !key_read;  // pulse after first sample
            result_valid <= 1'b0;
            if (key_read) begin  // token acts on the pulse cycle
                case (token.kind)
                    TOK_DIGIT: begin
                        if (digit_fits) entry <= appended[DATA_WIDTH-1:0];  // else dropped
                    end
                    TOK_SIGN: begin
                        entry     <= -entry;
                        entry_neg <= !entry_neg;
                    end
                    TOK_OP: begin
                        operand_a <= entry;
                        op        <= token.payload.op.code;
                        entry     <= '0;  // start operand b
                        entry_neg <= 1'b0;
                    end
                    TOK_EQ: begin
                        entry        <= sum_out;  // result becomes next operand
                        entry_neg    <= sum_out[DATA_WIDTH-1];
                        overflow     <= arith_overflow;
                        result_valid <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign operand_b     = entry;  // second operand is what was typed
    assign display_value = entry;

endmodule

//--- logic/calc_pkg.sv
package calc_pkg;

    // what a token carries
    typedef enum logic [1:0] {
        TOK_DIGIT = 2'd0,  // payload read as digit
        TOK_OP    = 2'd1,  // payload read as operator
        TOK_EQ    = 2'd2,  // equals key
        TOK_SIGN  = 2'd3   // sign toggle key
    } token_kind_t;

    // operator codes as the keypad reports them
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,  // nothing stored yet
        OP_MINUS = 3'd1,  // minus symbol on sign key
        OP_ADD   = 3'd2,
        OP_SUB   = 3'd3,
        OP_MUL   = 3'd4
    } op_code_t;

    // operator view of the payload
    typedef struct packed {
        logic     spare;  // always zero
        op_code_t code;
    } op_field_t;

    // one 4-bit payload decoded two ways
    typedef union packed {
        logic [3:0] digit;  // 0 to 9
        op_field_t  op;
    } key_payload_u;

    // token from scanner to controller
    typedef struct packed {
        token_kind_t  kind;
        key_payload_u payload;
    } key_token_t;

    // key index is row*4 + column
    localparam logic [3:0] KEY_ADD  = 4'd3;   // row 0 col 3
    localparam logic [3:0] KEY_SUB  = 4'd7;   // row 1 col 3
    localparam logic [3:0] KEY_MUL  = 4'd11;  // row 2 col 3
    localparam logic [3:0] KEY_EQ   = 4'd12;  // row 3 col 0
    localparam logic [3:0] KEY_NONE = 4'd14;  // unused key
    localparam logic [3:0] KEY_SIGN = 4'd15;  // row 3 col 3

endpackage

//--- logic/calc_top.sv
`timescale 1ns/1ps

module calc_top #(
    parameter int DEBOUNCE_CYCLES = 10,  // scanner stable count
    parameter int DATA_WIDTH      = 16   // operand width
) (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic [3:0]                   row_in,         // keypad rows
    output logic [3:0]                   col_out,        // keypad columns
    output logic signed [DATA_WIDTH-1:0] display_value,
    output logic                         result_valid,   // pulse per equals
    output logic                         overflow
);
    import calc_pkg::*;

    key_token_t                   token;
    logic                         read_input;
    logic                         key_read;
    logic signed [DATA_WIDTH-1:0] operand_a;
    logic signed [DATA_WIDTH-1:0] operand_b;
    op_code_t                     op;
    logic signed [DATA_WIDTH-1:0] sum_out;
    logic                         arith_overflow;

    keypad_scanner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) scanner_i (
        .clk       (clk),
        .nRST      (nRST),
        .row_in    (row_in),
        .col_out   (col_out),
        .key_read  (key_read),
        .read_input(read_input),
        .token     (token)
    );

    calc_controller #(
        .DATA_WIDTH(DATA_WIDTH)
    ) controller_i (
        .clk           (clk),
        .nRST          (nRST),
        .read_input    (read_input),
        .token         (token),
        .key_read      (key_read),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .op            (op),
        .sum_out       (sum_out),
        .arith_overflow(arith_overflow),
        .display_value (display_value),
        .result_valid  (result_valid),
        .overflow      (overflow)
    );

    calc_arith #(
        .DATA_WIDTH(DATA_WIDTH)
    ) arith_i (
        .operand_a(operand_a),
        .operand_b(operand_b),
        .op       (op),
        .sum_out  (sum_out),
        .overflow (arith_overflow)
    );

endmodule

//--- logic/keypad_scanner.sv
`timescale 1ns/1ps

module keypad_scanner #(
    parameter int DEBOUNCE_CYCLES = 10  // stable pressed cycles to accept
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [3:0]           row_in,      // pulled up, low when pressed
    output logic [3:0]           col_out,     // one column low at a time
    input  logic                 key_read,    // consume pulse from controller
    output logic                 read_input,  // token waiting
    output calc_pkg::key_token_t token
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    typedef enum logic [1:0] {
        SCAN,
        DEBOUNCE,
        CONFIRM,
        WAIT_RELEASE
    } scan_state_t;

    scan_state_t      state;
    logic [3:0]       row_mid;     // first sync stage
    logic [3:0]       row_sync;    // second sync stage
    logic [1:0]       col_idx;     // active column
    logic [1:0]       col_d1;      // column behind row_mid
    logic [1:0]       col_d2;      // column behind row_sync
    logic [CNT_W-1:0] stable_cnt;
    logic             pressed;     // any synced row low
    logic             aligned;     // row_sync belongs to col_idx
    logic             accept;      // last debounce cycle passed
    logic [1:0]       low_row;
    logic [3:0]       key_idx;
    key_token_t       key_tok;

    // key index to token
    function automatic key_token_t encode_token(input logic [3:0] key);
        key_token_t tok;
        tok.kind = TOK_DIGIT;
        tok.payload.digit = 4'd0;
        case (key)
            4'd0, 4'd1, 4'd2:  tok.payload.digit = key + 4'd1;  // top row 1..3
            4'd4, 4'd5, 4'd6:  tok.payload.digit = key;         // 4..6
            4'd8, 4'd9, 4'd10: tok.payload.digit = key - 4'd1;  // 7..9
            4'd13:             tok.payload.digit = 4'd0;
            KEY_ADD: begin
                tok.kind = TOK_OP;
                tok.payload.op.spare = 1'b0;
                tok.payload.op.code = OP_ADD;
            end
            KEY_SUB: begin
                tok.kind = TOK_OP;
                tok.payload.op.spare = 1'b0;
                tok.payload.op.code = OP_SUB;
            end
            KEY_MUL: begin
                tok.kind = TOK_OP;
                tok.payload.op.spare = 1'b0;
                tok.payload.op.code = OP_MUL;
            end
            KEY_EQ:   tok.kind = TOK_EQ;
            KEY_SIGN: begin
                tok.kind = TOK_SIGN;
                tok.payload.op.spare = 1'b0;
                tok.payload.op.code = OP_MINUS;  // minus symbol
            end
            default: ;  // unused key never leaves
        endcase
        return tok;
    endfunction

    // two-flop row sync with matching column history
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_mid  <= 4'hF;  // released
            row_sync <= 4'hF;
            col_d1   <= 2'd0;
            col_d2   <= 2'd0;
        end else begin
            row_mid  <= row_in;
            row_sync <= row_mid;
            col_d1   <= col_idx;
            col_d2   <= col_d1;
        end
    end

    assign col_out = ~(4'b0001 << col_idx);  // active low column
    assign pressed = ~&row_sync;
    assign aligned = (col_d2 == col_idx);

    // lowest low row wins
    always_comb begin
        low_row = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_sync[r]) low_row = 2'(r);
        end
    end

    assign key_idx = {low_row, col_idx};
    assign key_tok = encode_token(key_idx);
    assign accept  = (state == DEBOUNCE) && aligned && pressed &&
                     (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= SCAN;
            col_idx    <= 2'd0;
            stable_cnt <= '0;
            read_input <= 1'b0;
        end else begin
            case (state)
                SCAN: begin
                    if (pressed) begin
                        col_idx    <= col_d2;  // back to column that pulled the row
                        stable_cnt <= '0;
                        state      <= DEBOUNCE;
                    end else begin
                        col_idx <= col_idx + 2'd1;  // wraps after col 3
                    end
                end
                DEBOUNCE: begin
                    if (aligned) begin  // hold until pipeline refilled
                        if (!pressed) begin
                            stable_cnt <= '0;
                            state      <= SCAN;  // bounce, rescan
                        end else if (accept) begin
                            stable_cnt <= '0;
                            if (key_idx == KEY_NONE) begin
                                state <= WAIT_RELEASE;  // no token for it
                            end else begin
                                read_input <= 1'b1;
                                state      <= CONFIRM;
                            end
                        end else begin
                            stable_cnt <= stable_cnt + 1'b1;
                        end
                    end
                end
                CONFIRM: begin
                    if (key_read) begin  // presses ignored till then
                        read_input <= 1'b0;
                        state      <= WAIT_RELEASE;
                    end
                end
                WAIT_RELEASE: begin
                    if (!pressed) state <= SCAN;  // all rows high again
                end
                default: state <= SCAN;
            endcase
        end
    end

    // token held steady while read_input is up
    always_ff @(posedge clk) begin
        if (accept) token <= key_tok;
    end

endmodule

//--- sim.f
logic/calc_pkg.sv
logic/keypad_scanner.sv
logic/calc_controller.sv
logic/calc_arith.sv
logic/calc_top.sv
verification/keypad_model.sv
verification/calc_props.sv
verification/calc_tb.sv

//--- verification/calc_props.sv
`timescale 1ns/1ps

module calc_props (
    input logic       clk,
    input logic       nRST,
    input logic       read_input,    // scanner token waiting
    input logic       key_read,      // controller consume pulse
    input logic [3:0] col_out,
    input logic       result_valid
);

    // token stays offered until consumed
    token_held: assert property (@(posedge clk) disable iff (!nRST)
        read_input && !key_read |=> read_input)
        else $error("read_input dropped before key_read");

    // one pulse per token, scanner lets go right after
    key_read_pulse: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read && !read_input)
        else $error("key_read longer than one cycle or read_input still high after it");

    // column frozen while a token waits
    column_frozen: assert property (@(posedge clk) disable iff (!nRST)
        read_input |-> $stable(col_out))
        else $error("col_out moved while a token was waiting");

    result_pulse: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |=> !result_valid)
        else $error("result_valid longer than one cycle");

endmodule

// handshake wires between scanner and controller live in the top
bind calc_top calc_props props_i (
    .clk         (clk),
    .nRST        (nRST),
    .read_input  (read_input),
    .key_read    (key_read),
    .col_out     (col_out),
    .result_valid(result_valid)
);

//--- verification/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;

    localparam int DEBOUNCE_CYCLES = 10;
    localparam int DATA_WIDTH      = 16;
    localparam int HOLD_CYCLES     = 4 + DEBOUNCE_CYCLES + 8 + 6;  // press to token, worst phase
    localparam int PRESS_BOUND     = HOLD_CYCLES + 40;  // hold, gap, checks, reset share
    localparam int MAX_WORDS       = 128;

    logic                         clk;
    logic                         nRST;
    logic [3:0]                   row_in;
    logic [3:0]                   col_out;
    logic signed [DATA_WIDTH-1:0] display_value;
    logic                         result_valid;
    logic                         overflow;
    logic [3:0]                   key_sel;       // key under the finger
    logic                         key_down;

    logic [31:0]                  vectors [MAX_WORDS];
    logic                         loaded = 1'b0;  // watchdog waits on this
    int                           seed;
    int                           num_words;
    int                           errors;
    int                           test_errors;
    int                           result_seen;   // result_valid pulses so far
    logic signed [DATA_WIDTH-1:0] result_value;
    logic                         result_ovf;

    calc_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .DATA_WIDTH     (DATA_WIDTH)
    ) calc_top_i (
        .clk          (clk),
        .nRST         (nRST),
        .row_in       (row_in),
        .col_out      (col_out),
        .display_value(display_value),
        .result_valid (result_valid),
        .overflow     (overflow)
    );

    keypad_model keypad_i (
        .col_out(col_out),
        .key    (key_sel),
        .pressed(key_down),
        .row_in (row_in)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // catch each result pulse with its values
    always @(posedge clk) begin
        if (result_valid) begin
            result_seen  <= result_seen + 1;
            result_value <= display_value;
            result_ovf   <= overflow;
        end
    end

    task automatic reset_dut();
        @(posedge clk);
        nRST <= 1'b0;
        repeat (10) @(posedge clk);
        nRST <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    // hold a key until its token is taken, or a fixed time
    task automatic press_key(input logic [3:0] key, input logic short_press,
                             output logic consumed);
        int n;
        int hold;
        int gap;
        consumed = 1'b0;
        hold     = short_press ? DEBOUNCE_CYCLES / 2 : HOLD_CYCLES;  // bounce too short to count
        gap      = 4 + ($random(seed) & 7);  // random release gap
        @(posedge clk);
        key_sel  <= key;
        key_down <= 1'b1;
        for (n = 0; n < hold && !consumed; n++) begin
            @(posedge clk);
            if (calc_top_i.key_read) consumed = 1'b1;
        end
        key_down <= 1'b0;
        for (n = 0; n < gap; n++) begin  // a late token still counts
            @(posedge clk);
            if (calc_top_i.key_read) consumed = 1'b1;
        end
    endtask

    task automatic check_value(input string name, input logic signed [DATA_WIDTH-1:0] expected,
                               input logic signed [DATA_WIDTH-1:0] actual);
        assert (actual === expected) else begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    // word: test, key, flags (result, overflow, bounce, no token), display
    task automatic apply_word(input logic [31:0] word);
        logic [3:0]                   key;
        logic [3:0]                   flags;
        logic signed [DATA_WIDTH-1:0] expected;
        logic                         consumed;
        int                           seen_before;
        key         = word[27:24];
        flags       = word[23:20];
        expected    = word[15:0];
        seen_before = result_seen;
        press_key(key, flags[2], consumed);
        if (flags[3]) begin
            assert (!consumed) else begin
                $display("key %0d produced a token where none should exist", key);
                test_errors++;
            end
        end else begin
            assert (consumed) else begin
                $display("key %0d was not taken within %0d cycles", key, HOLD_CYCLES);
                test_errors++;
            end
        end
        @(posedge clk);
        check_value("display_value", expected, display_value);
        if (flags[0]) begin
            assert (result_seen == seen_before + 1) else begin
                $display("key %0d gave %0d result pulses instead of one", key,
                         result_seen - seen_before);
                test_errors++;
            end
            check_value("result", expected, result_value);
            check_value("overflow", DATA_WIDTH'(flags[1]), DATA_WIDTH'(result_ovf));
        end else begin
            assert (result_seen == seen_before) else begin
                $display("key %0d raised result_valid unexpectedly", key);
                test_errors++;
            end
        end
    endtask

    initial begin
        int idx;
        int presses;
        int tests_run;
        logic [3:0] test_id;
        seed        = 49;
        errors      = 0;
        tests_run   = 0;
        result_seen = 0;
        nRST        = 1'b0;
        key_sel     = 4'd0;
        key_down    = 1'b0;
        for (idx = 0; idx < MAX_WORDS; idx++) vectors[idx] = '0;
        $readmemh("verification/calc_vectors.txt", vectors);
        num_words = 0;
        while (num_words < MAX_WORDS && vectors[num_words][31:28] != 4'd0) num_words++;
        loaded = 1'b1;
        assert (num_words > 0) else begin
            $display("no vectors read from verification/calc_vectors.txt");
            errors++;
        end
        idx = 0;
        while (idx < num_words) begin
            test_id     = vectors[idx][31:28];
            test_errors = 0;
            presses     = 0;
            reset_dut();  // each test starts from a clear entry
            while (idx < num_words && vectors[idx][31:28] == test_id) begin
                apply_word(vectors[idx]);
                idx++;
                presses++;
            end
            tests_run++;
            errors += test_errors;
            $display("test %0d: %0d presses, %0d errors", test_id, presses, test_errors);
        end
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // limit scales with number of presses
    initial begin
        wait (loaded);
        repeat (num_words * PRESS_BOUND + 100) @(posedge clk);
        $display("watchdog expired, %0d presses did not finish in time", num_words);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- verification/calc_vectors.txt
// one test per line, one hex word per key press
// [31:28] test [27:24] key [23:20] flags: 1 result 2 overflow 4 bounce 8 no token [15:0] display
10000001 1100000C 1200007B 1D0004CE  // 1 2 3 0
20000001 2100000C 23000000 28000007 2C100013  // 12 + 7 =
35000005 37000000 3A000009 3C10FFFC  // 5 - 9 =
46000006 4B000000 48000007 4C10002A  // 6 * 7 =
55000005 5F00FFFB 5B000000 52000003 5C10FFF1  // 5 sign * 3 =
62000003 6D00001E 6D00012C 6B000000 62000003 6D00001E 6D00012C 6C305F90  // 300 * 300 =
74000004 7E800004 75C00004 7100002A  // 4 / key 14 / short 5 / 2
81000002 83000000 82000003 8C100005 8B000000 84000004 8C100014  // 2 + 3 = * 4 =

//--- verification/keypad_model.sv
`timescale 1ns/1ps

module keypad_model (
    input  logic [3:0] col_out,  // scanner columns, active low
    input  logic [3:0] key,      // row*4 + column
    input  logic       pressed,  // switch closed
    output logic [3:0] row_in    // pulled up when idle
);
    logic [1:0] key_row;
    logic [1:0] key_col;

    assign key_row = key[3:2];
    assign key_col = key[1:0];

    // closed switch shorts its row to its column
    always_comb begin
        row_in = 4'hF;  // pull-ups
        if (pressed && !col_out[key_col]) begin
            row_in[key_row] = 1'b0;  // only while its column is driven
        end
    end

endmodule
